//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_ro_stage
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# an aborted run never prints the fail message, so its exit status counts too
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- free_list.sv
`timescale 1ns/1ps

module free_list import ro_mem_pkg::*; #(
   parameter type entry_t = tag_t,
   parameter int  DEPTH   = N_TAGS
) (
   input  logic   clk,
   input  logic   rstn,
   input  logic   push,
   input  entry_t push_id,
   input  logic   pop,
   output entry_t head_id,
   output logic   empty,
   output logic   full
);

   typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
   typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

   entry_t ids [DEPTH];
   ptr_t   rd_ptr;
   ptr_t   wr_ptr;
   cnt_t   count;

   function automatic ptr_t ptr_inc(ptr_t p);
      return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;   // full ring, write side sits on the read side
         count  <= cnt_t'(DEPTH);
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= entry_t'(i);
         end
      end else begin
         if (push) begin
            ids[wr_ptr] <= push_id;
            wr_ptr      <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign head_id = ids[rd_ptr];
   assign empty   = (count == '0);
   assign full    = (count == cnt_t'(DEPTH));   // every ID is home

endmodule

//--- lane_arbiter.sv
`timescale 1ns/1ps

module lane_arbiter import ro_task_pkg::*; (
   input  logic [N_LANES-1:0] req_valid,
   input  logic               can_accept,
   output logic [N_LANES-1:0] req_ready,
   output logic               accept,
   output lane_t              accept_lane
);

   logic  any_valid;
   lane_t top_lane;

   // priority encoder, the highest lane wins since it is assigned last
   always_comb begin
      any_valid = 1'b0;
      top_lane  = '0;
      for (int i = 0; i < N_LANES; i++) begin
         if (req_valid[i]) begin
            any_valid = 1'b1;
            top_lane  = lane_t'(i);
         end
      end
   end

   assign accept      = any_valid & can_accept;
   assign accept_lane = top_lane;

   always_comb begin
      req_ready = '0;
      if (accept) begin
         req_ready[top_lane] = 1'b1;
      end
   end

endmodule

//--- line_read_issuer.sv
`timescale 1ns/1ps

module line_read_issuer import ro_mem_pkg::*, ro_task_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  accept,
   input  lane_t                 accept_lane,
   input  addr_t [N_LANES-1:0]   req_addr,
   input  len_t  [N_LANES-1:0]   req_len,
   input  ctx_t  [N_LANES-1:0]   req_ctx,
   output logic                  can_accept,
   input  logic                  thread_empty,
   input  thread_t               thread_head,
   output logic                  thread_pop,
   input  logic                  tag_empty,
   input  tag_t                  tag_head,
   output logic                  tag_pop,
   output logic                  arvalid,
   input  logic                  arready,
   output addr_t                 araddr,
   output tag_t                  arid,
   output logic                  ctx_we,
   output thread_t               ctx_thread,
   output thread_ctx_t           ctx_wdata,
   output logic                  tag_we,
   output tag_t                  tag_waddr,
   output mshr_entry_t           tag_wdata,
   output thread_t               accept_thread,
   output len_t                  accept_len
);

   logic       busy;
   addr_t      cur_addr;
   len_t       remaining;   // pairs not yet covered by a read
   pair_idx_t  run_idx;
   thread_t    cur_thread;
   pair_slot_t slot;
   len_t       room;
   len_t       n_read;
   logic       last_read;
   pair_mask_t mask;

   assign slot      = pair_slot_t'(cur_addr >> 3);
   assign room      = len_t'(PAIRS_PER_LINE) - len_t'(slot);   // pairs up to the line end
   assign last_read = (remaining <= room);
   assign n_read    = last_read ? remaining : room;

   always_comb begin
      for (int i = 0; i < PAIRS_PER_LINE; i++) begin
         mask[i] = (len_t'(i) >= len_t'(slot)) && (len_t'(i) < len_t'(slot) + n_read);
      end
   end

   assign arvalid    = busy & !tag_empty;
   assign araddr     = cur_addr;
   assign arid       = tag_head;
   assign tag_pop    = arvalid & arready;
   assign can_accept = !thread_empty & (!busy | (tag_pop & last_read));
   assign thread_pop = accept;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (tag_pop && last_read) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req_addr[accept_lane];
         remaining  <= req_len[accept_lane];
         run_idx    <= '0;
         cur_thread <= thread_head;
      end else if (tag_pop) begin
         cur_addr  <= (cur_addr & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);
         remaining <= remaining - n_read;
         run_idx   <= run_idx + pair_idx_t'(n_read);
      end
   end

   assign tag_we    = tag_pop;
   assign tag_waddr = tag_head;
   assign tag_wdata = '{thread: cur_thread, mask: mask, start_idx: run_idx};

   assign ctx_we     = accept;
   assign ctx_thread = thread_head;
   assign ctx_wdata  = '{lane: accept_lane, ctx: req_ctx[accept_lane]};

   // a zero length marks a cycle without accept, real lengths start at 1
   assign accept_thread = thread_head;
   assign accept_len    = accept ? req_len[accept_lane] : '0;

endmodule

//--- list.f
ro_mem_pkg.sv
ro_task_pkg.sv
free_list.sv
lane_arbiter.sv
line_read_issuer.sv
mshr_table.sv
pair_unpacker.sv
ro_stage.sv
ro_stage_assertions.sv
tb_ro_stage.sv

//--- mshr_table.sv
`timescale 1ns/1ps

module mshr_table import ro_mem_pkg::*, ro_task_pkg::*; (
   input  logic        clk,
   input  logic        tag_we,
   input  tag_t        tag_waddr,
   input  mshr_entry_t tag_wdata,
   input  tag_t        tag_raddr,
   output mshr_entry_t tag_rdata,
   input  logic        ctx_we,
   input  thread_t     ctx_thread,
   input  thread_ctx_t ctx_wdata,
   input  thread_t     ctx_raddr,
   output thread_ctx_t ctx_rdata
);

   mshr_entry_t tag_mem [N_TAGS];      // one record per outstanding read
   thread_ctx_t ctx_mem [N_THREADS];   // one record per request in flight

   always_ff @(posedge clk) begin
      if (tag_we) begin
         tag_mem[tag_waddr] <= tag_wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (ctx_we) begin
         ctx_mem[ctx_thread] <= ctx_wdata;
      end
   end

   assign tag_rdata = tag_mem[tag_raddr];
   assign ctx_rdata = ctx_mem[ctx_raddr];

endmodule

//--- pair_unpacker.sv
`timescale 1ns/1ps

module pair_unpacker import ro_mem_pkg::*, ro_task_pkg::*; (
   input  logic        clk,
   input  logic        rstn,
   input  logic        rvalid,
   output logic        rready,
   input  tag_t        rid,
   input  line_t       rdata,
   output tag_t        tag_raddr,
   input  mshr_entry_t tag_rdata,
   output thread_t     ctx_raddr,
   input  thread_ctx_t ctx_rdata,
   input  thread_t     accept_thread,
   input  len_t        accept_len,
   output logic        tag_push,
   output tag_t        tag_push_id,
   output logic        thread_push,
   output thread_t     thread_push_id,
   output logic        out_valid,
   input  logic        out_ready,
   output pair_t       out_data,
   output lane_t       out_lane,
   output ctx_t        out_ctx,
   output pair_idx_t   out_idx,
   output logic        out_last
);

   logic       hold;
   line_t      line_q;
   pair_mask_t mask_q;
   thread_t    thread_q;
   pair_idx_t  start_q;
   pair_slot_t sent_q;      // pairs already sent from this line
   pair_slot_t slot;
   pair_mask_t next_mask;
   logic       take;
   logic       fire;
   len_t       rem [N_THREADS];

   // lowest set bit of the mask
   always_comb begin
      slot = '0;
      for (int i = PAIRS_PER_LINE - 1; i >= 0; i--) begin
         if (mask_q[i]) begin
            slot = pair_slot_t'(i);
         end
      end
   end

   assign next_mask = mask_q & ~(pair_mask_t'(1) << slot);
   assign fire      = out_valid & out_ready;
   assign rready    = !hold | (fire & (next_mask == '0));
   assign take      = rvalid & rready;

   assign tag_raddr   = rid;
   assign tag_push    = take;
   assign tag_push_id = rid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold <= 1'b0;
      end else if (take) begin
         hold <= 1'b1;
      end else if (fire && next_mask == '0) begin
         hold <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         line_q   <= rdata;
         mask_q   <= tag_rdata.mask;
         thread_q <= tag_rdata.thread;
         start_q  <= tag_rdata.start_idx;
         sent_q   <= '0;
      end else if (fire) begin
         mask_q <= next_mask;
         sent_q <= sent_q + 1'b1;
      end
   end

   // pairs still owed per thread, loaded at accept
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++) begin
            rem[t] <= '0;
         end
      end else begin
         if (fire) begin
            rem[thread_q] <= rem[thread_q] - 1'b1;
         end
         if (accept_len != '0) begin
            rem[accept_thread] <= accept_len;
         end
      end
   end

   assign ctx_raddr = thread_q;

   assign out_valid = hold;
   assign out_data  = line_q[slot * $bits(pair_t) +: $bits(pair_t)];
   assign out_lane  = ctx_rdata.lane;
   assign out_ctx   = ctx_rdata.ctx;
   assign out_idx   = start_q + pair_idx_t'(sent_q);
   assign out_last  = (rem[thread_q] == len_t'(1));

   assign thread_push    = fire & out_last;   // final pair frees the thread
   assign thread_push_id = thread_q;

endmodule

//--- ro_mem_pkg.sv
package ro_mem_pkg;

   typedef logic [31:0]  addr_t;    // byte address
   typedef logic [511:0] line_t;    // one cache line as returned by memory
   typedef logic [63:0]  pair_t;

   localparam int PAIRS_PER_LINE = 8;
   localparam int LINE_BYTES     = PAIRS_PER_LINE * $bits(pair_t) / 8;

   typedef logic [$clog2(PAIRS_PER_LINE)-1:0] pair_slot_t;
   typedef logic [PAIRS_PER_LINE-1:0]         pair_mask_t;  // pairs of a line wanted by a read

   // read IDs, one per outstanding line read
   localparam int N_TAGS = 32;

   typedef logic [$clog2(N_TAGS)-1:0] tag_t;

endpackage

//--- ro_stage.sv
`timescale 1ns/1ps

module ro_stage import ro_mem_pkg::*, ro_task_pkg::*; (
   input  logic                clk,
   input  logic                rstn,
   input  logic [N_LANES-1:0]  req_valid,
   output logic [N_LANES-1:0]  req_ready,
   input  addr_t [N_LANES-1:0] req_addr,
   input  len_t  [N_LANES-1:0] req_len,
   input  ctx_t  [N_LANES-1:0] req_ctx,
   output logic                arvalid,
   input  logic                arready,
   output addr_t               araddr,
   output tag_t                arid,
   input  logic                rvalid,
   output logic                rready,
   input  tag_t                rid,
   input  line_t               rdata,
   output logic                out_valid,
   input  logic                out_ready,
   output pair_t               out_data,
   output lane_t               out_lane,
   output ctx_t                out_ctx,
   output pair_idx_t           out_idx,
   output logic                out_last,
   output logic                idle
);

   logic        accept;
   lane_t       accept_lane;
   logic        can_accept;
   logic        thread_empty;
   thread_t     thread_head;
   logic        thread_pop;
   logic        thread_push;
   thread_t     thread_push_id;
   logic        tag_empty;
   tag_t        tag_head;
   logic        tag_pop;
   logic        tag_push;
   tag_t        tag_push_id;
   logic        ctx_we;
   thread_t     ctx_thread;
   thread_ctx_t ctx_wdata;
   thread_t     ctx_raddr;
   thread_ctx_t ctx_rdata;
   logic        tag_we;
   tag_t        tag_waddr;
   mshr_entry_t tag_wdata;
   tag_t        tag_raddr;
   mshr_entry_t tag_rdata;
   thread_t     accept_thread;
   len_t        accept_len;

   lane_arbiter u_lane_arbiter (
      .req_valid   (req_valid),
      .can_accept  (can_accept),
      .req_ready   (req_ready),
      .accept      (accept),
      .accept_lane (accept_lane)
   );

   line_read_issuer u_issuer (
      .clk           (clk),
      .rstn          (rstn),
      .accept        (accept),
      .accept_lane   (accept_lane),
      .req_addr      (req_addr),
      .req_len       (req_len),
      .req_ctx       (req_ctx),
      .can_accept    (can_accept),
      .thread_empty  (thread_empty),
      .thread_head   (thread_head),
      .thread_pop    (thread_pop),
      .tag_empty     (tag_empty),
      .tag_head      (tag_head),
      .tag_pop       (tag_pop),
      .arvalid       (arvalid),
      .arready       (arready),
      .araddr        (araddr),
      .arid          (arid),
      .ctx_we        (ctx_we),
      .ctx_thread    (ctx_thread),
      .ctx_wdata     (ctx_wdata),
      .tag_we        (tag_we),
      .tag_waddr     (tag_waddr),
      .tag_wdata     (tag_wdata),
      .accept_thread (accept_thread),
      .accept_len    (accept_len)
   );

   mshr_table u_mshr_table (
      .clk       (clk),
      .tag_we    (tag_we),
      .tag_waddr (tag_waddr),
      .tag_wdata (tag_wdata),
      .tag_raddr (tag_raddr),
      .tag_rdata (tag_rdata),
      .ctx_we    (ctx_we),
      .ctx_thread(ctx_thread),
      .ctx_wdata (ctx_wdata),
      .ctx_raddr (ctx_raddr),
      .ctx_rdata (ctx_rdata)
   );

   pair_unpacker u_unpacker (
      .clk            (clk),
      .rstn           (rstn),
      .rvalid         (rvalid),
      .rready         (rready),
      .rid            (rid),
      .rdata          (rdata),
      .tag_raddr      (tag_raddr),
      .tag_rdata      (tag_rdata),
      .ctx_raddr      (ctx_raddr),
      .ctx_rdata      (ctx_rdata),
      .accept_thread  (accept_thread),
      .accept_len     (accept_len),
      .tag_push       (tag_push),
      .tag_push_id    (tag_push_id),
      .thread_push    (thread_push),
      .thread_push_id (thread_push_id),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out_data       (out_data),
      .out_lane       (out_lane),
      .out_ctx        (out_ctx),
      .out_idx        (out_idx),
      .out_last       (out_last)
   );

   free_list #(.entry_t(tag_t), .DEPTH(N_TAGS)) u_tag_pool (
      .clk     (clk),
      .rstn    (rstn),
      .push    (tag_push),
      .push_id (tag_push_id),
      .pop     (tag_pop),
      .head_id (tag_head),
      .empty   (tag_empty),
      .full    ()
   );

   // all threads home means nothing in flight
   free_list #(.entry_t(thread_t), .DEPTH(N_THREADS)) u_thread_pool (
      .clk     (clk),
      .rstn    (rstn),
      .push    (thread_push),
      .push_id (thread_push_id),
      .pop     (thread_pop),
      .head_id (thread_head),
      .empty   (thread_empty),
      .full    (idle)
   );

endmodule

//--- ro_stage_assertions.sv
`timescale 1ns/1ps

module ro_stage_assertions import ro_mem_pkg::*, ro_task_pkg::*; (
   input logic               clk,
   input logic               rstn,
   input logic [N_LANES-1:0] req_ready,
   input logic               arvalid,
   input logic               arready,
   input addr_t              araddr,
   input tag_t               arid,
   input logic               rvalid,
   input logic               rready,
   input logic               out_valid,
   input logic               out_ready,
   input pair_t              out_data,
   input lane_t              out_lane,
   input ctx_t               out_ctx,
   input pair_idx_t          out_idx,
   input logic               out_last
);

   // read address holds until the memory takes it
   a_ar_stable: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
      else $error("read address dropped or changed before arready");

   a_out_stable: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_lane)
                                  && $stable(out_ctx) && $stable(out_idx) && $stable(out_last))
      else $error("output dropped or changed before out_ready");

   a_ready_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(req_ready))
      else $error("more than one lane ready");

   // a held line only makes room when its last pair leaves
   a_rready_room: assert property (@(posedge clk) disable iff (!rstn)
      rready && out_valid |-> out_ready)
      else $error("rready high while the unpacker is full");

   // with no new response the freed unpacker shows no pair in the next cycle
   a_rready_drain: assert property (@(posedge clk) disable iff (!rstn)
      rready && out_valid && !rvalid |=> !out_valid)
      else $error("rready high while pairs of the held line remain");

endmodule

//--- ro_task_pkg.sv
package ro_task_pkg;

   import ro_mem_pkg::*;

   localparam int N_LANES   = 4;
   localparam int N_THREADS = 8;
   localparam int MAX_PAIRS = 32;

   typedef logic [$clog2(N_LANES)-1:0]   lane_t;
   typedef logic [$clog2(N_THREADS)-1:0] thread_t;
   typedef logic [$clog2(MAX_PAIRS):0]   len_t;       // 1 to MAX_PAIRS, needs the extra bit
   typedef logic [$clog2(MAX_PAIRS)-1:0] pair_idx_t;
   typedef logic [15:0]                  ctx_t;

   // what a read tag stands for
   typedef struct packed {
      thread_t    thread;
      pair_mask_t mask;
      pair_idx_t  start_idx;   // request index of the first wanted pair of the line
   } mshr_entry_t;

   typedef struct packed {
      lane_t lane;
      ctx_t  ctx;
   } thread_ctx_t;

endpackage

//--- tb_ro_stage.sv
`timescale 1ns/1ps

module tb_ro_stage import ro_mem_pkg::*, ro_task_pkg::*; ;

   localparam int N_TEST1     = 12;
   localparam int N_TEST2     = 16;
   localparam int N_TEST3     = 24;
   localparam int N_TEST4     = 40;
   localparam int N_TEST5     = 12;
   localparam int MAX_REQ     = N_TEST1 + N_TEST2 + N_TEST3 + N_TEST4 + N_TEST5;
   localparam int MAX_DELAY   = 8;   // largest random gap between requests on a lane
   localparam int TIMEOUT_CYC = MAX_REQ * (MAX_PAIRS + MAX_DELAY) * 4;

   logic                clk;
   logic                rstn;
   logic [N_LANES-1:0]  req_valid;
   logic [N_LANES-1:0]  req_ready;
   addr_t [N_LANES-1:0] req_addr;
   len_t  [N_LANES-1:0] req_len;
   ctx_t  [N_LANES-1:0] req_ctx;
   logic                arvalid;
   logic                arready;
   addr_t               araddr;
   tag_t                arid;
   logic                rvalid;
   logic                rready;
   tag_t                rid;
   line_t               rdata;
   logic                out_valid;
   logic                out_ready;
   pair_t               out_data;
   lane_t               out_lane;
   ctx_t                out_ctx;
   pair_idx_t           out_idx;
   logic                out_last;
   logic                idle;

   logic [31:0] rng_state;
   string       test_name;
   int          error_count;
   int          errors_at_start;
   int          tests_passed;
   int          tests_failed;
   int          cycle_count;

   // one record per request and the request number doubles as its ctx
   int                   r_lane  [MAX_REQ];
   addr_t                r_addr  [MAX_REQ];
   int                   r_len   [MAX_REQ];
   int                   r_count [MAX_REQ];
   int                   r_reads [MAX_REQ];
   logic [MAX_PAIRS-1:0] r_seen  [MAX_REQ];
   int                   n_req;
   int                   done_total;
   int                   test_accepted;

   int                 lane_list [N_LANES][MAX_REQ];
   int                 lane_head [N_LANES];
   int                 lane_tail [N_LANES];
   int                 lane_cur  [N_LANES];   // -1 when the lane shows nothing
   int                 lane_gap  [N_LANES];
   logic [N_LANES-1:0] lane_taken;

   int gap_max;
   int arready_pct;
   int out_ready_pct;
   int resp_pct;
   bit resp_shuffle;

   // memory model
   addr_t pend_addr [$];
   tag_t  pend_id [$];
   bit    resp_busy;

   // request whose reads are being issued
   int    iss_req;
   addr_t iss_next;
   int    iss_rem;

   ro_stage u_ro_stage (
      .clk       (clk),
      .rstn      (rstn),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_len   (req_len),
      .req_ctx   (req_ctx),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .arid      (arid),
      .rvalid    (rvalid),
      .rready    (rready),
      .rid       (rid),
      .rdata     (rdata),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_lane  (out_lane),
      .out_ctx   (out_ctx),
      .out_idx   (out_idx),
      .out_last  (out_last),
      .idle      (idle)
   );

   bind ro_stage ro_stage_assertions u_ro_stage_assertions (
      .clk       (clk),
      .rstn      (rstn),
      .req_ready (req_ready),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .arid      (arid),
      .rvalid    (rvalid),
      .rready    (rready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_lane  (out_lane),
      .out_ctx   (out_ctx),
      .out_idx   (out_idx),
      .out_last  (out_last)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int random_below(int n);
      return int'((next_random() >> 8) % n);
   endfunction

   function automatic addr_t random_addr();
      return addr_t'(next_random() & 32'h000f_fff8);
   endfunction

   // memory contents as a scrambled copy of the word address
   function automatic logic [31:0] mem_word(addr_t a);
      logic [31:0] h;
      h = a ^ 32'h9e37_79b9;
      h = h * 32'h85eb_ca6b;
      return h ^ (h >> 13);
   endfunction

   function automatic pair_t pair_at(addr_t a);
      return {mem_word(a + addr_t'(4)), mem_word(a)};
   endfunction

   function automatic line_t line_at(addr_t a);
      line_t l;
      addr_t base;
      base = a & ~addr_t'(63);
      for (int i = 0; i < 16; i++) begin
         l[i*32 +: 32] = mem_word(base + addr_t'(4 * i));
      end
      return l;
   endfunction

   function automatic int lines_touched(addr_t a, int len);
      return (int'(a[5:3]) + len + 7) / 8;
   endfunction

   function automatic logic [N_LANES-1:0] highest_onehot(logic [N_LANES-1:0] v);
      logic [N_LANES-1:0] r;
      r = '0;
      for (int i = N_LANES - 1; i >= 0; i--) begin
         if (v[i] && r == '0) begin
            r[i] = 1'b1;
         end
      end
      return r;
   endfunction

   task automatic check_equal(string what, logic [63:0] expected, logic [63:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("error %0s %0s: expected %0h actual %0h", test_name, what, expected, actual);
      end
   endtask

   task automatic report_failure(string msg);
      error_count++;
      $display("failure in %0s: %0s", test_name, msg);
   endtask

   task automatic add_request(int lane, addr_t addr, int len);
      r_lane[n_req]  = lane;
      r_addr[n_req]  = addr;
      r_len[n_req]   = len;
      r_count[n_req] = 0;
      r_reads[n_req] = 0;
      r_seen[n_req]  = '0;
      lane_list[lane][lane_tail[lane]] = n_req;
      lane_tail[lane]++;
      n_req++;
   endtask

   task automatic add_random_requests(int count, int lane, int max_len);
      int    l;
      addr_t a;
      int    len;
      for (int i = 0; i < count; i++) begin
         l   = (lane < 0) ? random_below(N_LANES) : lane;
         a   = random_addr();
         len = 1 + random_below(max_len);
         add_request(l, a, len);
      end
   endtask

   // slot plus length lands in the line after the wanted number of crossings
   task automatic add_split_requests(int count);
      int    crossings;
      int    slot;
      int    lo;
      int    hi;
      int    l;
      addr_t base;
      for (int i = 0; i < count; i++) begin
         crossings = 1 + i % 4;
         slot      = (crossings == 4) ? 1 + random_below(7) : random_below(8);
         lo        = 8 * crossings + 1 - slot;
         hi        = 8 * crossings + 8 - slot;
         if (hi > MAX_PAIRS) begin
            hi = MAX_PAIRS;
         end
         l    = random_below(N_LANES);
         base = random_addr() & ~addr_t'(63);
         add_request(l, base + addr_t'(8 * slot), lo + random_below(hi - lo + 1));
      end
   endtask

   task automatic set_traffic(int gap, int ar_pct, int out_pct, int r_pct, bit shuffle);
      gap_max       = gap;
      arready_pct   = ar_pct;
      out_ready_pct = out_pct;
      resp_pct      = r_pct;
      resp_shuffle  = shuffle;
   endtask

   // sampled at the falling edge where everything has settled
   task automatic observe();
      int n;
      int room;
      int covered;
      bit reused;
      if (req_ready != '0) begin
         check_equal("req_ready", highest_onehot(req_valid), req_ready);
      end
      lane_taken = req_valid & req_ready;

      // reads before accepts since the last read may share its cycle with the next accept
      if (arvalid && arready) begin
         reused = resp_busy && (rid == arid);
         for (int i = 0; i < pend_id.size(); i++) begin
            if (pend_id[i] == arid) begin
               reused = 1'b1;
            end
         end
         if (reused) begin
            report_failure("a read tag was issued while a read with that tag is outstanding");
         end
         if (iss_rem <= 0) begin
            report_failure("a read was issued with no request left to cover");
         end else begin
            check_equal("araddr", iss_next, araddr);
            room     = 8 - int'(iss_next[5:3]);
            covered  = (iss_rem < room) ? iss_rem : room;
            iss_rem  = iss_rem - covered;
            iss_next = (iss_next & ~addr_t'(63)) + addr_t'(64);
            r_reads[iss_req]++;
         end
         pend_addr.push_back(araddr);
         pend_id.push_back(arid);
      end

      for (int l = 0; l < N_LANES; l++) begin
         if (lane_taken[l]) begin
            if (iss_rem != 0) begin
               report_failure("a request was accepted before the previous one issued all reads");
            end
            iss_req  = lane_cur[l];
            iss_next = r_addr[iss_req];
            iss_rem  = r_len[iss_req];
            test_accepted++;
         end
      end

      if (rvalid && rready) begin
         resp_busy = 1'b0;
      end

      if (out_valid && out_ready) begin
         n = int'(out_ctx);
         if (n >= n_req) begin
            report_failure("output carries a context that was never requested");
         end else if (int'(out_idx) >= r_len[n]) begin
            report_failure("output index lies beyond the request length");
         end else if (r_seen[n][out_idx]) begin
            report_failure("output index repeated within one request");
         end else begin
            r_seen[n][out_idx] = 1'b1;
            r_count[n]++;
            check_equal("out_lane", r_lane[n], out_lane);
            check_equal("out_data", pair_at(r_addr[n] + addr_t'(8 * int'(out_idx))), out_data);
            check_equal("out_last", r_count[n] == r_len[n], out_last);
            if (r_count[n] == r_len[n]) begin
               check_equal("reads per request", lines_touched(r_addr[n], r_len[n]), r_reads[n]);
               done_total++;
            end
         end
      end
   endtask

   task automatic drive();
      int k;
      for (int l = 0; l < N_LANES; l++) begin
         if (lane_taken[l]) begin
            lane_cur[l] = -1;
            lane_gap[l] = random_below(gap_max + 1);
         end
         if (lane_cur[l] < 0) begin
            if (lane_gap[l] > 0) begin
               lane_gap[l]--;
            end else if (lane_head[l] < lane_tail[l]) begin
               lane_cur[l] = lane_list[l][lane_head[l]];
               lane_head[l]++;
            end
         end
         req_valid[l] = (lane_cur[l] >= 0);
         if (lane_cur[l] >= 0) begin
            req_addr[l] = r_addr[lane_cur[l]];
            req_len[l]  = len_t'(r_len[lane_cur[l]]);
            req_ctx[l]  = ctx_t'(lane_cur[l]);
         end
      end
      lane_taken = '0;

      arready   = random_below(100) < arready_pct;
      out_ready = random_below(100) < out_ready_pct;

      // a presented response holds until rready
      if (!resp_busy && pend_addr.size() > 0 && random_below(100) < resp_pct) begin
         k     = resp_shuffle ? random_below(pend_addr.size()) : 0;
         rid   = pend_id[k];
         rdata = line_at(pend_addr[k]);
         pend_addr.delete(k);
         pend_id.delete(k);
         resp_busy = 1'b1;
      end
      rvalid = resp_busy;
   endtask

   always begin
      @(negedge clk);
      if (rstn) begin
         observe();
      end
      @(posedge clk);
      #1;
      drive();
   end

   task automatic init_state();
      clk         = 1'b0;
      rstn        = 1'b0;
      req_valid   = '0;
      req_addr    = '0;
      req_len     = '0;
      req_ctx     = '0;
      arready     = 1'b0;
      rvalid      = 1'b0;
      rid         = '0;
      rdata       = '0;
      out_ready   = 1'b0;
      rng_state   = 32'h5fc786e4;
      error_count = 0;
      n_req       = 0;
      done_total  = 0;
      resp_busy   = 1'b0;
      iss_req     = 0;
      iss_next    = '0;
      iss_rem     = 0;
      lane_taken  = '0;
      for (int l = 0; l < N_LANES; l++) begin
         lane_head[l] = 0;
         lane_tail[l] = 0;
         lane_cur[l]  = -1;
         lane_gap[l]  = 0;
      end
      set_traffic(0, 0, 0, 0, 1'b0);
   endtask

   task automatic start_test(string name);
      test_name       = name;
      errors_at_start = error_count;
      test_accepted   = 0;
   endtask

   task automatic finish_test();
      while (done_total < n_req) begin
         @(posedge clk);
      end
      @(negedge clk);
      check_equal("idle after drain", 1, idle);
      check_equal("reads left unanswered", 0, pend_addr.size());
      if (error_count == errors_at_start) begin
         tests_passed++;
         $display("test %0s passed", test_name);
      end else begin
         tests_failed++;
         $display("test %0s failed with %0d errors", test_name, error_count - errors_at_start);
      end
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYC) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      tests_passed = 0;
      tests_failed = 0;
      init_state();
      repeat (8) @(posedge clk);
      #1;
      rstn = 1'b1;

      start_test("single_lane_data");
      set_traffic(0, 100, 100, 100, 1'b0);
      add_random_requests(N_TEST1, 2, MAX_PAIRS);
      finish_test();

      start_test("line_split");
      set_traffic(2, 80, 100, 100, 1'b0);
      add_split_requests(N_TEST2);
      finish_test();

      start_test("arbitration");
      set_traffic(0, 60, 100, 100, 1'b1);
      add_random_requests(N_TEST3, -1, MAX_PAIRS);
      finish_test();

      start_test("reorder_backpressure");
      set_traffic(MAX_DELAY, 70, 50, 40, 1'b1);
      add_random_requests(N_TEST4, -1, MAX_PAIRS);
      finish_test();

      // output stalled so no thread ever comes home
      start_test("thread_limit");
      set_traffic(0, 100, 0, 100, 1'b1);
      add_random_requests(N_TEST5, -1, 8);
      while (test_accepted < N_THREADS) begin
         @(posedge clk);
      end
      repeat (64) @(posedge clk);
      @(negedge clk);
      check_equal("accepted while stalled", N_THREADS, test_accepted);
      check_equal("idle while stalled", 0, idle);
      out_ready_pct = 100;
      finish_test();

      $display("%0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
